// File: source/alu_pkg.sv
// ALU subsystem package: control and flag structs, write-target codes, row-A select names
package alu_pkg;

   // Command control word, 9 bits, MSB first
   typedef struct packed {
      logic       sel_add;  // Row B: 1 = A+QQ+cin, 0 = ~(A^QQ)
      logic [1:0] sel_a;    // Row A operation
      logic [3:0] wtarget;  // Write target of the microinstruction
      logic       cin;      // Carry into bit 0
      logic       cc_load;  // Load condition flags from this result
   } alu_ctrl_t;

   // Condition flags as seen by the branch logic
   typedef struct packed {
      logic zero;   // Result all zero
      logic neg;    // Result MSB
      logic carry;  // Carry out of the adder
      logic ovf;    // Signed overflow of the adder
   } alu_flags_t;

   // Write-target codes that matter to the ALU
   localparam logic [3:0] WT_TIMER   = 4'b1011;  // Write to low word of mtime
   localparam logic [3:0] WT_INSTRET = 4'b1001;  // Write to minstret

   // Row A selections
   //  sel_a  A
   //  00     di
   //  01     ~(di ^ adr)
   //  10     ~di & ~adr
   //  11     0
   localparam logic [1:0] SEL_A_DI   = 2'b00;  // Pass first operand
   localparam logic [1:0] SEL_A_XNOR = 2'b01;  // Near-XOR with adr
   localparam logic [1:0] SEL_A_NOR  = 2'b10;  // NOR with adr
   localparam logic [1:0] SEL_A_ZERO = 2'b11;  // Constant zero

   // Combined with row B this gives, for example:
   //  sel_add=1, sel_a=DI   : di + qq + cin (subtract when qq is inverted and cin=1)
   //  sel_add=1, sel_a=ZERO : qq + cin
   //  sel_add=0, sel_a=DI   : ~(di ^ qq)
   //  sel_add=0, sel_a=ZERO : ~qq

endpackage

// File: source/operand_stage.sv
// Operand stage: input register capturing one ALU command per valid strobe
`timescale 1ns/1ps

module operand_stage import alu_pkg::*; #(
   parameter int alu_width = 32
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cmd_valid,  // Command strobe
   input  logic [alu_width-1:0] di,         // First operand
   input  logic [alu_width-1:0] adr,        // Normal second operand
   input  logic [alu_width-1:0] qq,         // Alternate second operand
   input  alu_ctrl_t            ctrl,       // Control word
   output logic                 s_valid,    // Registered strobe
   output logic [alu_width-1:0] s_di,
   output logic [alu_width-1:0] s_adr,
   output logic [alu_width-1:0] s_qq,
   output alu_ctrl_t            s_ctrl
);

   // Strobe and control word, cleared by reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_valid <= 1'b0;
         s_ctrl  <= '0;
      end else begin
         s_valid <= cmd_valid;          // One-cycle pulse per command
         if (cmd_valid) s_ctrl <= ctrl; // Hold last command otherwise
      end
   end

   // Operand words
   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         s_di  <= di;
         s_adr <= adr;
         s_qq  <= qq;
      end
   end

   // Registered command is exactly the one presented one edge earlier
   a_capture : assert property (@(posedge clk) disable iff (!rst_n)
      s_valid |-> $past(cmd_valid) && s_di == $past(di) && s_ctrl == $past(ctrl));

endmodule

// File: source/alu_core.sv
// ALU core: two-row combinational ALU, carry chain, mtime tap and minstret overflow detect
`timescale 1ns/1ps

module alu_core import alu_pkg::*; #(
   parameter int alu_width        = 32,
   parameter int mtime_tap        = 12,
   parameter int mtime_tap_lowlim = 8
) (
   input  logic [alu_width-1:0] s_di,        // First operand
   input  logic [alu_width-1:0] s_adr,       // Normal second operand
   input  logic [alu_width-1:0] s_qq,        // Alternate second operand
   input  alu_ctrl_t            s_ctrl,      // Registered control word
   output logic [alu_width-1:0] b,           // ALU result
   output logic                 a31,         // MSB of row A, for overflow flag
   output logic                 carry_out,   // Carry out of MSB, 0 when not adding
   output logic                 tap_event,   // mtime tap bit toggles
   output logic                 instret_ofl  // minstret wraps
);

   logic [alu_width-1:0] a;        // Row A output
   logic [alu_width:0]   sum;      // Row B adder incl. carry
   logic                 is_wtime; // Write to low mtime word
   logic                 is_winst; // Write to minstret

   // Row A
   always_comb begin
      case (s_ctrl.sel_a)
         SEL_A_DI:   a = s_di;
         SEL_A_XNOR: a = ~(s_di ^ s_adr);
         SEL_A_NOR:  a = ~s_di & ~s_adr;
         default:    a = '0;        // SEL_A_ZERO
      endcase
   end
   assign a31 = a[alu_width-1];

   // Row B with carry chain
   assign sum = {1'b0, a} + {1'b0, s_qq} + {{alu_width{1'b0}}, s_ctrl.cin};

   always_comb begin
      if (s_ctrl.sel_add) begin
         b         = sum[alu_width-1:0];
         carry_out = sum[alu_width];
      end else begin
         b         = ~(a ^ s_qq);
         carry_out = 1'b0;          // No carry outside ADD
      end
   end

   // Write-target decode
   assign is_wtime = s_ctrl.wtarget == WT_TIMER;
   assign is_winst = s_ctrl.wtarget == WT_INSTRET;

   // Tap and overflow detect, only when the tap is slow enough for CSR sequences
   if (mtime_tap < mtime_tap_lowlim) begin : g_no_tap
      assign tap_event   = 1'b0;
      assign instret_ofl = 1'b0;
   end else begin : g_tap
      if (mtime_tap >= alu_width) begin : g_tap_msb
         // Tap beyond the word: count a 0 to 1 transition of the MSB
         assign tap_event = ~a[alu_width-1] & b[alu_width-1] & is_wtime;
      end else begin : g_tap_bit
         // Tapped bit changed during the mtime update
         assign tap_event = (a[mtime_tap] ^ b[mtime_tap]) & is_wtime;
      end
      assign instret_ofl = carry_out & is_winst; // Counter wrapped
   end

endmodule

// File: source/result_stage.sv
// Result stage: result register, result valid strobe and condition flag register
`timescale 1ns/1ps

module result_stage import alu_pkg::*; #(
   parameter int alu_width = 32
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 s_valid,      // ALU inputs hold a command
   input  logic [alu_width-1:0] b,            // ALU result
   input  logic                 a31,          // Row A MSB
   input  logic                 carry_out,    // Adder carry
   input  logic                 qq_msb,       // MSB of second adder operand
   input  logic                 cc_load,      // Flag load request
   output logic [alu_width-1:0] result,
   output logic                 result_valid, // One pulse per command
   output alu_flags_t           flags
);

   alu_flags_t flags_next; // Flags of the current result

   always_comb begin
      flags_next.zero  = b == '0;
      flags_next.neg   = b[alu_width-1];
      flags_next.carry = carry_out;
      // Operands of same sign, result sign differs
      flags_next.ovf   = (a31 == qq_msb) && (b[alu_width-1] != a31);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         result       <= '0;
         result_valid <= 1'b0;
         flags        <= '0;
      end else begin
         result_valid <= s_valid;
         if (s_valid) result <= b;                       // Payload follows strobe
         if (s_valid && cc_load) flags <= flags_next;    // Otherwise hold
      end
   end

   // A flag load from a non-add command (carry_out low) leaves carry clear
   a_carry_only_add : assert property (@(posedge clk) disable iff (!rst_n)
      (s_valid && cc_load && !carry_out) |=> !flags.carry);

endmodule

// File: source/irq_pending.sv
// Interrupt pending: sticky timer-tick and minstret overflow requests with acknowledge
`timescale 1ns/1ps

module irq_pending #(
   parameter int mtime_tap        = 12,
   parameter int mtime_tap_lowlim = 8
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       s_valid,      // Qualifies the ALU events
   input  logic       tap_event,    // mtime tap toggled
   input  logic       instret_ofl,  // minstret wrapped
   input  logic [1:0] irq_ack,      // Bit 0 timer, bit 1 instret
   output logic       irq_timer,
   output logic       irq_instret
);

   // Requests exist only when the tap is in the legal range
   localparam bit irq_en = mtime_tap >= mtime_tap_lowlim;

   logic set_timer;   // Qualified timer event
   logic set_instret; // Qualified counter event

   assign set_timer   = irq_en && s_valid && tap_event;
   assign set_instret = irq_en && s_valid && instret_ofl;

   // Set wins over acknowledge in the same cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         irq_timer   <= 1'b0;
         irq_instret <= 1'b0;
      end else begin
         irq_timer   <= set_timer   || (irq_timer   && !irq_ack[0]);
         irq_instret <= set_instret || (irq_instret && !irq_ack[1]);
      end
   end

   // A request only rises after a valid ALU event
   a_timer_rise : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(irq_timer) |-> $past(s_valid && tap_event));
   a_instret_rise : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(irq_instret) |-> $past(s_valid && instret_ofl));

   // Acknowledge without a new event drops the request
   a_timer_ack : assert property (@(posedge clk) disable iff (!rst_n)
      (irq_ack[0] && !set_timer) |=> !irq_timer);
   a_instret_ack : assert property (@(posedge clk) disable iff (!rst_n)
      (irq_ack[1] && !set_instret) |=> !irq_instret);

endmodule

// File: source/alu_subsys_top.sv
// ALU subsystem top: operand stage, ALU core, result stage and interrupt pending logic
`timescale 1ns/1ps

module alu_subsys_top import alu_pkg::*; #(
   parameter int alu_width        = 32,
   parameter int mtime_tap        = 12,  // mtime bit that raises the timer tick
   parameter int mtime_tap_lowlim = 8    // Lowest tap usable with CSR sequences
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 cmd_valid,
   input  logic [alu_width-1:0] di,
   input  logic [alu_width-1:0] adr,
   input  logic [alu_width-1:0] qq,
   input  alu_ctrl_t            ctrl,
   input  logic [1:0]           irq_ack,      // Bit 0 timer, bit 1 instret
   output logic [alu_width-1:0] result,
   output logic                 result_valid,
   output alu_flags_t           flags,
   output logic                 irq_timer,
   output logic                 irq_instret
);

   logic                 s_valid;
   logic [alu_width-1:0] s_di, s_adr, s_qq; // Registered operands
   alu_ctrl_t            s_ctrl;
   logic [alu_width-1:0] b;                 // Combinational ALU result
   logic                 a31, carry_out, tap_event, instret_ofl;

   operand_stage #(.alu_width(alu_width)) i_operand_stage (
      .clk, .rst_n, .cmd_valid, .di, .adr, .qq, .ctrl,
      .s_valid, .s_di, .s_adr, .s_qq, .s_ctrl
   );

   alu_core #(
      .alu_width       (alu_width),
      .mtime_tap       (mtime_tap),
      .mtime_tap_lowlim(mtime_tap_lowlim)
   ) i_alu_core (
      .s_di, .s_adr, .s_qq, .s_ctrl,
      .b, .a31, .carry_out, .tap_event, .instret_ofl
   );

   result_stage #(.alu_width(alu_width)) i_result_stage (
      .clk, .rst_n, .s_valid, .b, .a31, .carry_out,
      .qq_msb (s_qq[alu_width-1]),       // Second adder operand sign
      .cc_load(s_ctrl.cc_load),
      .result, .result_valid, .flags
   );

   irq_pending #(
      .mtime_tap       (mtime_tap),
      .mtime_tap_lowlim(mtime_tap_lowlim)
   ) i_irq_pending (
      .clk, .rst_n, .s_valid, .tap_event, .instret_ofl, .irq_ack,
      .irq_timer, .irq_instret
   );

endmodule

// File: dv/alu_ref_model.svh
// Testbench reference model: expected-cycle struct, ALU and flag prediction, request update
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Expected outcome of one driven cycle, sized by alu_width of the including module
typedef struct packed {
   logic                 valid;    // cmd_valid was high
   logic                 cc_load;  // Flags get loaded
   logic [alu_width-1:0] result;   // Expected ALU result
   alu_flags_t           flags;    // Flags as they would load
   logic                 tap;      // Valid timer tap event
   logic                 ofl;      // Valid instret overflow event
} cmd_exp_t;

// Predicts result, flags and events of one command from the ALU and flag rules
function automatic cmd_exp_t predict_cmd(input logic v, input logic [alu_width-1:0] di,
   input logic [alu_width-1:0] adr, input logic [alu_width-1:0] qq, input alu_ctrl_t c);
   cmd_exp_t             e;
   logic [alu_width-1:0] a;
   logic [alu_width-1:0] b;
   logic                 cy;
   int                   i;
   if (c.sel_a == SEL_A_DI) a = di;
   else if (c.sel_a == SEL_A_XNOR) a = di ~^ adr;
   else if (c.sel_a == SEL_A_NOR) a = ~(di | adr);
   else a = '0;
   cy = 1'b0;
   if (c.sel_add) begin
      cy = c.cin;
      for (i = 0; i < alu_width; i++) begin  // Bit-serial ripple carry
         b[i] = a[i] ^ qq[i] ^ cy;
         cy   = (a[i] & qq[i]) | (cy & (a[i] | qq[i]));
      end
   end else begin
      b = a ~^ qq;
   end
   e.valid       = v;
   e.cc_load     = c.cc_load;
   e.result      = b;
   e.flags.zero  = ~|b;
   e.flags.neg   = b[alu_width-1];
   e.flags.carry = cy;
   e.flags.ovf   = (a[alu_width-1] == qq[alu_width-1]) && (b[alu_width-1] != a[alu_width-1]);
   e.tap         = v && (c.wtarget == WT_TIMER) && (a[mtime_tap] != b[mtime_tap]);
   e.ofl         = v && (c.wtarget == WT_INSTRET) && cy;
   return e;
endfunction

// Sticky request, a new event beats the acknowledge
function automatic logic next_request(input logic pend, input logic set, input logic ack);
   return set || (pend && !ack);
endfunction

`endif

// File: dv/tb_alu_subsys.sv
// Testbench for the ALU subsystem: clock, reset, seeded random commands, scoreboard, timeout
`timescale 1ns/1ps

module tb_alu_subsys import alu_pkg::*; ();

   localparam int alu_width     = 32;
   localparam int mtime_tap     = 12;
   localparam int reset_cycles  = 10;
   localparam int n_idle        = 4;    // Checks of the reset state
   localparam int n_rand        = 600;
   localparam int n_sub         = 8;    // Directed subtractions
   localparam int n_dir         = 8;    // Directed timer and instret commands
   localparam int n_drain       = 6;
   localparam int total_cycles  = reset_cycles + n_idle + n_rand + n_sub + n_dir + n_drain;
   localparam int timeout_limit = 2 * total_cycles + 100;

   logic                 clk;
   logic                 rst_n;
   logic                 cmd_valid;
   logic [alu_width-1:0] di, adr, qq;
   alu_ctrl_t            ctrl;
   logic [1:0]           irq_ack;
   logic [alu_width-1:0] result;
   logic                 result_valid;
   alu_flags_t           flags;
   logic                 irq_timer, irq_instret;

   `include "alu_ref_model.svh"

   cmd_exp_t             pipe_q[$];     // Two commands in flight
   logic [alu_width-1:0] exp_result;
   logic                 exp_rvalid;
   alu_flags_t           exp_flags;
   logic                 exp_timer, exp_instret;
   logic [1:0]           last_ack;      // Ack seen at the next rising edge
   int                   err_cnt, chk_cnt, cycle_cnt;

   alu_subsys_top i_dut (.*);

   initial clk = 1'b0;
   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= timeout_limit) begin
         $display("Timeout: run did not finish within %0d cycles", timeout_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic compare_signal(input string name, input logic [31:0] got,
      input logic [31:0] exp);
      chk_cnt++;
      assert (got === exp) else begin
         err_cnt++;
         $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   // One falling edge: retire the oldest command into the model, check, then drive
   task automatic drive_cycle(input logic v, input logic [alu_width-1:0] d,
      input logic [alu_width-1:0] a, input logic [alu_width-1:0] q, input alu_ctrl_t c,
      input logic [1:0] ack);
      cmd_exp_t e;
      @(negedge clk);
      e = '0;
      if (pipe_q.size() == 2) e = pipe_q.pop_front();  // Sampled two edges ago
      exp_rvalid = e.valid;
      if (e.valid) exp_result = e.result;
      if (e.valid && e.cc_load) exp_flags = e.flags;
      exp_timer   = next_request(exp_timer, e.tap, last_ack[0]);
      exp_instret = next_request(exp_instret, e.ofl, last_ack[1]);
      compare_signal("result", result, exp_result);
      compare_signal("result_valid", 32'(result_valid), 32'(exp_rvalid));
      compare_signal("flags", 32'(flags), 32'(exp_flags));
      compare_signal("irq_timer", 32'(irq_timer), 32'(exp_timer));
      compare_signal("irq_instret", 32'(irq_instret), 32'(exp_instret));
      cmd_valid = v;
      di        = d;
      adr       = a;
      qq        = q;
      ctrl      = c;
      irq_ack   = ack;
      last_ack  = ack;
      pipe_q.push_back(predict_cmd(v, d, a, q, c));
   endtask

   task automatic random_cycle();
      alu_ctrl_t   c;
      logic [31:0] r;
      logic [1:0]  ack;
      r = $urandom;
      c = r[8:0];
      case (r[10:9])                    // Bias toward the two CSR targets
         2'd0:    c.wtarget = WT_TIMER;
         2'd1:    c.wtarget = WT_INSTRET;
         default: ;
      endcase
      ack[0] = ($urandom % 6) == 0;
      ack[1] = ($urandom % 6) == 0;
      drive_cycle(r[11] | r[12], $urandom, $urandom, $urandom, c, ack);  // Mostly valid
   endtask

   // x - y as x + ~y + 1, adr left random
   task automatic sub_cycle(input logic [alu_width-1:0] x, input logic [alu_width-1:0] y);
      alu_ctrl_t c;
      c         = '0;
      c.sel_add = 1'b1;
      c.sel_a   = SEL_A_DI;
      c.cin     = 1'b1;
      c.cc_load = 1'b1;
      drive_cycle(1'b1, x, $urandom, ~y, c, 2'b00);
   endtask

   task automatic add_cycle(input logic [alu_width-1:0] x, input logic [alu_width-1:0] y,
      input logic [3:0] wt, input logic [1:0] ack);
      alu_ctrl_t c;
      c         = '0;
      c.sel_add = 1'b1;
      c.sel_a   = SEL_A_DI;
      c.wtarget = wt;
      c.cc_load = 1'b1;
      drive_cycle(1'b1, x, '0, y, c, ack);
   endtask

   initial begin
      void'($urandom(64587));
      err_cnt     = 0;
      chk_cnt     = 0;
      cycle_cnt   = 0;
      exp_result  = '0;
      exp_rvalid  = 1'b0;
      exp_flags   = '0;
      exp_timer   = 1'b0;
      exp_instret = 1'b0;
      last_ack    = 2'b00;
      rst_n       = 1'b0;
      cmd_valid   = 1'b0;
      di          = '0;
      adr         = '0;
      qq          = '0;
      ctrl        = '0;
      irq_ack     = 2'b00;
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      repeat (n_idle) drive_cycle(1'b0, '0, '0, '0, '0, 2'b00);  // Reset values hold
      repeat (n_rand) random_cycle();
      sub_cycle(32'h0000_0000, 32'h0000_0000);
      sub_cycle(32'h0000_0000, 32'h0000_0001);   // Borrow, result -1
      sub_cycle(32'h7fff_ffff, 32'hffff_ffff);   // Signed overflow up
      sub_cycle(32'h8000_0000, 32'h0000_0001);   // Signed overflow down
      sub_cycle(32'h7fff_ffff, 32'h8000_0000);
      sub_cycle(32'hffff_ffff, 32'hffff_ffff);
      sub_cycle(32'h0000_0001, 32'h0000_0002);
      sub_cycle(32'h8000_0000, 32'h7fff_ffff);
      add_cycle(32'h0000_0fff, 32'h1, WT_TIMER, 2'b01);    // Bit 12 toggles
      add_cycle(32'h0000_0fff, 32'h1, 4'h0, 2'b00);        // Same sum, no timer write
      add_cycle(32'h0000_0fff, 32'h1, 4'h3, 2'b01);        // Timer request acked
      add_cycle(32'hffff_ffff, 32'h1, WT_INSTRET, 2'b10);  // Counter wraps
      add_cycle(32'h0000_0001, 32'h1, WT_INSTRET, 2'b00);  // No carry
      add_cycle(32'h0000_0fff, 32'h1, WT_TIMER, 2'b11);
      add_cycle(32'hffff_ffff, 32'h1, WT_INSTRET, 2'b11);  // Ack meets new timer event
      add_cycle(32'h0000_0000, 32'h0, 4'h0, 2'b11);        // Ack meets new instret event
      repeat (2) drive_cycle(1'b0, '0, '0, '0, '0, 2'b11);
      repeat (n_drain - 2) drive_cycle(1'b0, '0, '0, '0, '0, 2'b00);
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+dv
source/alu_pkg.sv
source/operand_stage.sv
source/alu_core.sv
source/result_stage.sv
source/irq_pending.sv
source/alu_subsys_top.sv
dv/tb_alu_subsys.sv

// File: Makefile
TOP = tb_alu_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) --Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
